// ==== verilog.f ====
hw/spi_pkg.sv
hw/spi_slave_io.sv
hw/spi_slave_regs.sv
hw/spi_core_sync.sv
hw/spi_slave.sv
dv/spi_slave_asserts.sv
dv/spi_slave_tb.sv

// ==== Makefile ====
# Verilator flow for the SPI slave
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= spi_slave_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides pass or fail
sim: build
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/spi_slave_tb.sv ====
/*
 * testbench for the spi slave
 *  - sclk and core_clk generators, ss reset
 *  - spi master tasks for register and remote commands
 *  - xorshift stimulus, shadow registers, packet reference
 *  - access pulse checker, compare tasks and timeout
 */
`timescale 1ns/100ps
module spi_slave_tb;
   import spi_pkg::*;

   localparam int N_REG      = 12;             // random register writes
   localparam int N_MIXED    = 100;            // back to back transactions
   localparam int TXN_CYCLES = PW + 6;         // longest frame plus ss gaps
   localparam int N_TXN      = 2*14 + N_REG + N_MIXED + 8;
   // twice the worst case of every frame, plus reset and idle
   localparam int TIMEOUT_CYCLES = 2 * (20 + N_TXN * TXN_CYCLES);

   logic        sclk;
   logic        core_clk;
   logic        ss;
   logic        mosi;
   logic        miso;
   logic        core_spi_access;
   packet_t     core_spi_packet;
   logic        core_spi_read;

   logic [31:0] rng;
   logic        sent_bits [0:PW-1];         // frame as shifted, first bit at 0
   logic        got_bits  [1:PW];           // miso after rising edge n
   logic [7:0]  shadow    [1:REGS-1];       // expected register contents
   logic [7:0]  shadow_count;               // remote packets so far, mod 256
   int          cur_len;                    // value now in REG_LEN
   packet_t     exp_q [$];                  // packets waiting for a pulse
   logic        exp_rd_q [$];
   int          pulses_sent;
   int          pulses_seen;
   int          cycles = 0;

   //########################################
   // clocks and dut
   //########################################
   always #20 sclk = ~sclk;                 // 40 ns
   always #5 core_clk = ~core_clk;          // 10 ns, over twice sclk

   spi_slave dut0
   (
      .sclk            (sclk),
      .ss              (ss),
      .mosi            (mosi),
      .miso            (miso),
      .core_clk        (core_clk),
      .core_spi_access (core_spi_access),
      .core_spi_packet (core_spi_packet),
      .core_spi_read   (core_spi_read)
   );

   //########################################
   // reference and helpers
   //########################################
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // first bit lands at len-1, zero above the length
   function automatic packet_t expect_packet(input int len);
      packet_t p;
      p = '0;
      for (int i = 0; i < len; i++)
         p[len-1-i] = sent_bits[i];
      return p;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TESTS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         abort_run($sformatf("** Error at %0d ns: %s expected %h got %h",
                             $time, name, exp, act));
   endtask

   task automatic check_packet(input string name, input packet_t exp, input packet_t act);
      if (act !== exp)
         abort_run($sformatf("** Error at %0d ns: %s expected %h got %h",
                             $time, name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("** Error at %0d ns: %s expected %b got %b",
                             $time, name, exp, act));
   endtask

   //########################################
   // spi master
   //########################################
   // drives on falling edges, ss gap kept at the minimum
   task automatic shift_frame(input int len);
      @(negedge sclk);
      ss   = 1'b0;
      mosi = sent_bits[0];
      for (int i = 1; i <= len; i++)
      begin
         @(negedge sclk);
         got_bits[i] = miso;                // bit shown after edge i
         if (i < len)
            mosi = sent_bits[i];
      end
      mosi = 1'b0;
      repeat (2) @(negedge sclk);           // ss low 2 cycles after last bit
      ss = 1'b1;
      @(negedge sclk);                      // next frame adds the 2nd high cycle
   endtask

   task automatic reg_write(input logic [5:0] addr, input logic [7:0] data);
      logic [15:0] frame;
      frame = {OP_WRITE, addr, data};
      for (int i = 0; i < 16; i++)
         sent_bits[i] = frame[15-i];        // msb first
      shift_frame(16);
      if (addr != 6'(REG_COUNT) && addr < 6'(REGS))
         shadow[addr[3:0]] = data;          // count and high addresses ignored
   endtask

   task automatic reg_read(input logic [5:0] addr);
      logic [15:0] frame;
      logic [7:0]  got;
      logic [7:0]  exp;
      frame = {OP_READ, addr, 8'h00};       // dummy second byte
      for (int i = 0; i < 16; i++)
         sent_bits[i] = frame[15-i];
      shift_frame(16);
      for (int k = 0; k < 8; k++)
         got[7-k] = got_bits[8+k];          // data bit k after edge 8+k
      exp = (addr == 6'(REG_COUNT)) ? shadow_count : shadow[addr[3:0]];
      check_byte($sformatf("miso (register %0d)", addr), exp, got);
   endtask

   task automatic set_len(input int len);
      cur_len = len;
      reg_write(6'(REG_LEN), 8'(len));
   endtask

   // random packet, opcode in its first two bits
   task automatic remote_send(input spi_op_t op, input int len);
      for (int i = 0; i < len; i++)
      begin
         rng = xorshift32(rng);
         sent_bits[i] = rng[0];
      end
      sent_bits[0] = op[1];
      sent_bits[1] = op[0];
      exp_q.push_back(expect_packet(len));
      exp_rd_q.push_back(op == OP_RREAD);
      pulses_sent++;
      shift_frame(len);
      wait (pulses_seen == pulses_sent);    // timeout guards this
      shadow_count = shadow_count + 8'd1;
   endtask

   //########################################
   // checker and timeout
   //########################################
   always @(negedge core_clk)               // outputs settled mid cycle
   begin
      if (core_spi_access === 1'b1)
      begin
         if (exp_q.size() == 0)
            abort_run($sformatf("access pulse at %0d ns with no remote packet sent",
                                $time));
         else
         begin
            check_packet("core_spi_packet", exp_q.pop_front(), core_spi_packet);
            check_flag("core_spi_read", exp_rd_q.pop_front(), core_spi_read);
            pulses_seen++;
         end
      end
   end

   always @(posedge sclk)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
         abort_run($sformatf("timeout, run still going after %0d sclk cycles", cycles));
   end

   //########################################
   // test sequence
   //########################################
   initial
   begin
      sclk         = 1'b0;
      core_clk     = 1'b0;
      ss           = 1'b1;                  // reset from time 0
      mosi         = 1'b0;
      rng          = 32'hadd99998;
      shadow_count = 8'h00;                 // count starts at zero on power-up
      pulses_sent  = 0;
      pulses_seen  = 0;
      cur_len      = PW;

      // reset and idle
      repeat (5) @(negedge sclk);
      check_flag("core_spi_access", 1'b0, core_spi_access);
      check_flag("core_spi_read", 1'b0, core_spi_read);
      check_flag("miso", 1'b0, miso);
      repeat (20) @(negedge sclk);          // checker catches a stray pulse

      // register write and read back
      for (int a = 2; a < REGS; a++)
      begin
         rng = xorshift32(rng);
         reg_write(6'(a), rng[7:0]);
      end
      for (int n = 0; n < N_REG; n++)
      begin
         rng = xorshift32(rng);
         reg_write(6'(2 + rng[15:8] % 14), rng[7:0]);
      end
      for (int a = 2; a < REGS; a++)
         reg_read(6'(a));

      // count register is read only
      rng = xorshift32(rng);
      reg_write(6'(REG_COUNT), rng[7:0]);
      reg_read(6'(REG_COUNT));

      // remote write at full length
      set_len(PW);
      remote_send(OP_RWRITE, PW);
      reg_read(6'(REG_COUNT));

      // remote read, shorter packet
      rng = xorshift32(rng);
      set_len(16 + int'(rng % (PW - 15)));
      remote_send(OP_RREAD, cur_len);
      reg_read(6'(REG_LEN));

      // mixed traffic, minimum ss gap
      for (int n = 0; n < N_MIXED; n++)
      begin
         rng = xorshift32(rng);
         case (rng[1:0])
            2'd0: reg_write(6'(2 + rng[15:8] % 14), rng[23:16]);
            2'd1: reg_read(6'(rng[11:8]));  // any of the 16
            2'd2:
            begin
               if (rng[4])
                  remote_send(OP_RREAD, cur_len);
               else
                  remote_send(OP_RWRITE, cur_len);
            end
            default: set_len(16 + int'(rng[31:8] % (PW - 15)));
         endcase
      end

      repeat (4) @(negedge sclk);
      if (exp_q.size() == 0 && pulses_seen == pulses_sent)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
         abort_run("remote packets left without an access pulse");
   end

endmodule

// ==== dv/spi_slave_asserts.sv ====
/*
 * concurrent assertions for the spi slave
 *  - access pulse lasts one core cycle
 *  - no register write strobe while deselected
 *  - miso quiet while deselected
 *  - bind into the top level
 */
`timescale 1ns/100ps
module spi_slave_asserts
(
   input logic sclk,
   input logic ss,
   input logic core_clk,
   input logic core_spi_access,
   input logic spi_write,                  // internal strobe of the top level
   input logic miso
);

   //########################################
   // core side
   //########################################
   // one pulse per packet, never two cycles long
   a_access_one_cycle : assert property (
      @(posedge core_clk) disable iff (ss)
      core_spi_access |=> !core_spi_access)
      else $error("core_spi_access high for two core cycles in a row");

   //########################################
   // spi side
   //########################################
   a_no_write_deselected : assert property (
      @(posedge sclk)
      ss |-> !spi_write)                   // fsm held in idle
      else $error("spi_write high while ss is high");

   a_miso_low_deselected : assert property (
      @(posedge sclk)
      ss |-> !miso)                        // tx shifter cleared by ss
      else $error("miso high while ss is high");

endmodule

bind spi_slave spi_slave_asserts u_asserts
(
   .sclk            (sclk),
   .ss              (ss),
   .core_clk        (core_clk),
   .core_spi_access (core_spi_access),
   .spi_write       (spi_write),
   .miso            (miso)
);

// ==== hw/spi_slave.sv ====
/*
 * spi slave top level
 *  - decode stage on sclk
 *  - register file on sclk
 *  - result stage on core_clk
 */
`timescale 1ns/100ps
module spi_slave
(
   input  logic             sclk,            // spi clock
   input  logic             ss,              // slave select, high is reset
   input  logic             mosi,
   output logic             miso,
   input  logic             core_clk,
   output logic             core_spi_access, // one core cycle per packet
   output spi_pkg::packet_t core_spi_packet,
   output logic             core_spi_read
);
   import spi_pkg::*;

   logic       spi_write;
   logic [5:0] spi_addr;
   logic [7:0] spi_data;
   logic       packet_done;
   logic       packet_read;
   packet_t    spi_rx;
   regs_t      spi_regs;           // back to decode for reads and length

   spi_slave_io u_io
   (
      .sclk        (sclk),
      .ss          (ss),
      .mosi        (mosi),
      .miso        (miso),
      .spi_regs    (spi_regs),
      .spi_write   (spi_write),
      .spi_addr    (spi_addr),
      .spi_data    (spi_data),
      .packet_done (packet_done),
      .packet_read (packet_read),
      .spi_rx      (spi_rx)
   );

   spi_slave_regs u_regs
   (
      .sclk        (sclk),
      .ss          (ss),
      .spi_write   (spi_write),
      .spi_addr    (spi_addr),
      .spi_data    (spi_data),
      .packet_done (packet_done),
      .spi_regs    (spi_regs)
   );

   // crossing into the core clock
   spi_core_sync u_sync
   (
      .core_clk        (core_clk),
      .ss              (ss),
      .packet_done     (packet_done),
      .packet_read     (packet_read),
      .spi_rx          (spi_rx),
      .core_spi_access (core_spi_access),
      .core_spi_packet (core_spi_packet),
      .core_spi_read   (core_spi_read)
   );

endmodule

// ==== hw/spi_core_sync.sv ====
/*
 * result stage of the spi slave
 *  - two flop synchronizer of packet_done into core_clk
 *  - rising edge detect giving a one cycle access pulse
 *  - packet and read flag captured with the pulse
 */
`timescale 1ns/100ps
module spi_core_sync
(
   input  logic             core_clk,        // faster than twice sclk
   input  logic             ss,
   input  logic             packet_done,     // sclk domain level
   input  logic             packet_read,
   input  spi_pkg::packet_t spi_rx,          // frozen while done is high
   output logic             core_spi_access,
   output spi_pkg::packet_t core_spi_packet,
   output logic             core_spi_read
);

   logic done_s1;                    // first sync flop
   logic done_s2;                    // second sync flop
   logic done_s3;                    // edge detect history
   logic access_pulse;

   //########################################
   // synchronizer and edge detect
   //########################################
   always_ff @(posedge core_clk or posedge ss)
   begin
      if (ss)
      begin
         done_s1 <= 1'b0;
         done_s2 <= 1'b0;
         done_s3 <= 1'b0;
      end
      else
      begin
         done_s1 <= packet_done;
         done_s2 <= done_s1;
         done_s3 <= done_s2;
      end
   end

   assign access_pulse = done_s2 & ~done_s3;   // rise seen in core domain

   //########################################
   // core side outputs
   //########################################
   always_ff @(posedge core_clk or posedge ss)
   begin
      if (ss)
      begin
         core_spi_access <= 1'b0;
         core_spi_read   <= 1'b0;
      end
      else
      begin
         core_spi_access <= access_pulse;
         core_spi_read   <= access_pulse & packet_read;   // only with the pulse
      end
   end

   // packet lines up with the access pulse
   always_ff @(posedge core_clk)
   begin
      if (access_pulse)
         core_spi_packet <= spi_rx;
   end

endmodule

// ==== hw/spi_slave_regs.sv ====
/*
 * execute stage of the spi slave
 *  - registers 1 to 15 written on the spi write strobe
 *  - register 0 counts completed remote packets
 *  - flat view of all registers for the decode stage
 */
`timescale 1ns/100ps
module spi_slave_regs
(
   input  logic           sclk,
   input  logic           ss,
   input  logic           spi_write,     // one sclk strobe
   input  logic [5:0]     spi_addr,
   input  logic [7:0]     spi_data,
   input  logic           packet_done,
   output spi_pkg::regs_t spi_regs
);
   import spi_pkg::*;

   logic [7:0] regs_q [1:REGS-1];    // writable registers
   logic [7:0] pkt_cnt = 8'h00;      // counts from power-up
   logic       done_d;               // packet_done one edge late
   logic       wr_ok;

   // count register and unmapped addresses drop the write
   assign wr_ok = spi_write & (spi_addr < 6'(REGS)) & (spi_addr != 6'(REG_COUNT));

   always_ff @(posedge sclk)
   begin
      if (wr_ok)
         regs_q[spi_addr[3:0]] <= spi_data;
   end

   //########################################
   // remote packet counter
   //########################################
   always_ff @(posedge sclk or posedge ss)
   begin
      if (ss)
         done_d <= 1'b0;
      else
         done_d <= packet_done;
   end

   always_ff @(posedge sclk)
   begin
      if (packet_done & ~done_d)
         pkt_cnt <= pkt_cnt + 1'b1;    // wraps at 256
   end

   // flatten
   always_comb
   begin
      spi_regs[REG_COUNT*8 +: 8] = pkt_cnt;
      for (int i = 1; i < REGS; i++)
         spi_regs[i*8 +: 8] = regs_q[i];
   end

endmodule

// ==== hw/spi_slave_io.sv ====
/*
 * decode stage of the spi slave, all on sclk
 *  - rx shift register and bit counter
 *  - command decode into opcode and register address
 *  - transaction fsm from idle to done
 *  - tx shifter for register reads
 *  - register write strobe and remote packet done flag
 */
`timescale 1ns/100ps
module spi_slave_io
(
   input  logic             sclk,          // spi clock
   input  logic             ss,            // slave select, high is reset
   input  logic             mosi,
   output logic             miso,
   input  spi_pkg::regs_t   spi_regs,      // all registers
   output logic             spi_write,     // one sclk strobe
   output logic [5:0]       spi_addr,      // latched register address
   output logic [7:0]       spi_data,
   output logic             packet_done,   // held until ss rises
   output logic             packet_read,
   output spi_pkg::packet_t spi_rx
);
   import spi_pkg::*;

   spi_state_t       state;
   spi_state_t       state_nxt;
   spi_op_t          op_q;             // opcode of this transaction
   spi_op_t          cmd_op;           // opcode in the byte now completing
   logic [CNT_W-1:0] bit_count;        // bits sampled so far
   logic [CNT_W-1:0] cnt_nxt;
   logic [7:0]       rx_byte;          // byte finishing at this edge
   logic [7:0]       pkt_len;
   logic [7:0]       rd_byte;
   logic [7:0]       tx;
   logic             shift_en;
   logic             byte_end;
   logic             cmd_end;
   logic             remote_end;
   logic             done_q;

   //########################################
   // decode
   //########################################
   assign rx_byte    = {spi_rx[6:0], mosi};      // includes the bit sampled now
   assign cmd_op     = spi_op_t'(rx_byte[7:6]);
   assign shift_en   = (state != ST_DONE);       // sclk side freezes when done
   assign cnt_nxt    = bit_count + 1'b1;
   assign byte_end   = (bit_count[2:0] == 3'd7); // 8th bit of a byte
   assign cmd_end    = (state == ST_CMD) & byte_end;
   assign pkt_len    = spi_regs[REG_LEN*8 +: 8];
   assign remote_end = (state == ST_REMOTE) & (cnt_nxt == CNT_W'(pkt_len));

   // register byte picked straight from the command byte
   always_comb
   begin
      if (rx_byte[5:0] < 6'(REGS))
         rd_byte = spi_regs[{rx_byte[3:0], 3'b000} +: 8];
      else
         rd_byte = 8'h00;              // nothing above the last register
   end

   //########################################
   // fsm
   //########################################
   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:
            state_nxt = ST_CMD;        // first command bit sampled
         ST_CMD:
            if (byte_end)
            begin
               case (cmd_op)
                  OP_READ:  state_nxt = ST_READ;
                  OP_WRITE: state_nxt = ST_WRITE;
                  default:  state_nxt = ST_REMOTE;   // rwrite and rread
               endcase
            end
         ST_READ, ST_WRITE:
            if (byte_end)
               state_nxt = ST_DONE;    // second byte complete
         ST_REMOTE:
            if (remote_end)
               state_nxt = ST_DONE;
         default:
            state_nxt = state;         // done holds until ss
      endcase
   end

   always_ff @(posedge sclk or posedge ss)
   begin
      if (ss)
      begin
         state     <= ST_IDLE;
         bit_count <= '0;
         spi_rx    <= '0;
         done_q    <= 1'b0;
         op_q      <= OP_WRITE;
      end
      else
      begin
         state <= state_nxt;
         if (shift_en)
         begin
            spi_rx    <= {spi_rx[PW-2:0], mosi};   // msb first
            bit_count <= cnt_nxt;
         end
         if (cmd_end)
            op_q <= cmd_op;
         if (remote_end)
            done_q <= 1'b1;            // last packet bit sampled
      end
   end

   // address kept for the whole transaction
   always_ff @(posedge sclk)
   begin
      if (cmd_end)
         spi_addr <= rx_byte[5:0];
   end

   //########################################
   // tx shifter
   //########################################
   // loaded at the 8th edge so the msb is out before the falling edge
   always_ff @(posedge sclk or posedge ss)
   begin
      if (ss)
         tx <= 8'h00;
      else if (cmd_end & (cmd_op == OP_READ))
         tx <= rd_byte;
      else if (state == ST_READ)
         tx <= {tx[6:0], 1'b0};        // empty after the last bit
   end

   assign miso = tx[7];

   //########################################
   // outputs to regs and sync
   //########################################
   assign spi_write   = (state == ST_WRITE) & byte_end;  // written at the 16th edge
   assign spi_data    = rx_byte;
   assign packet_done = done_q;
   assign packet_read = (op_q == OP_RREAD);

endmodule

// ==== hw/spi_pkg.sv ====
/*
 * shared definitions for the spi slave
 *  - register file, packet and bit counter sizes
 *  - addresses of the special registers
 *  - opcode and fsm state enums
 *  - packet and flat register file types
 */
package spi_pkg;

   //########################################
   // sizes
   //########################################
   localparam int REGS  = 16;          // number of 8 bit registers
   localparam int AW    = 16;          // remote address width
   localparam int PW    = 2*AW + 40;   // 72 bit packet
   localparam int CNT_W = 8;           // bit counter width

   // special registers
   localparam int REG_COUNT = 0;       // read only remote packet count
   localparam int REG_LEN   = 1;       // remote packet length in bits (16 to PW)

   //########################################
   // enums
   //########################################
   // top two bits of the command byte
   typedef enum logic [1:0]
   {
      OP_WRITE  = 2'b00,               // register write
      OP_RREAD  = 2'b01,               // remote read
      OP_READ   = 2'b10,               // register read
      OP_RWRITE = 2'b11                // remote write
   } spi_op_t;

   typedef enum logic [2:0]
   {
      ST_IDLE,                         // nothing sampled yet
      ST_CMD,                          // shifting command byte
      ST_READ,                         // register byte out on miso
      ST_WRITE,                        // register byte in on mosi
      ST_REMOTE,                       // shifting remote packet
      ST_DONE                          // frozen until ss rises
   } spi_state_t;

   // received packet, first bit in the msb of the used length
   typedef logic [PW-1:0] packet_t;

   // all registers, register n in bits 8n+7 to 8n
   typedef logic [REGS*8-1:0] regs_t;

endpackage
